/* filelist.f */
hw/rvPkg.sv
hw/instrDecode.sv
hw/regFile.sv
hw/alu.sv
hw/dataMem.sv
hw/apbDebugPort.sv
hw/rvCore.sv
sim/rvCore_properties.sv
sim/rvCoreTb.sv

/* Makefile */
SIM := obj_dir/VrvCoreTb

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(wildcard hw/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module rvCoreTb -f filelist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/rvCoreTb.sv */
`timescale 1ns/100ps

module rvCoreTb;

    localparam int cycleLimit = 20000;
    localparam int numRegs    = 32;

    logic           clk;
    logic           arstN;
    logic           instrValid;
    logic [31:0]    instr;
    rvPkg::apbReq_t apbReq;
    rvPkg::apbRsp_t apbRsp;
    logic           illegalInstr;

    // Reference model state
    logic [31:0] mReg [numRegs];
    logic [31:0] mPc;
    logic [31:0] mMem [rvPkg::memWords];

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    rvCore rvCore_inst (
        .clk          (clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .apbReq       (apbReq),
        .apbRsp       (apbRsp),
        .illegalInstr (illegalInstr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Hang guard
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Checks and model helpers
    ////////////////////
    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I semantics per operation kind
    function automatic logic [31:0] aluRef(input int kind, input logic [31:0] a,
                                           input logic [31:0] b);
        case (kind)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return a << b[4:0];
            7: return a >> b[4:0];
            8: return $unsigned($signed(a) >>> b[4:0]);
            default: return 32'h0;
        endcase
    endfunction

    // funct7 and funct3 of the R-type kinds
    function automatic logic [9:0] rFunct(input int kind);
        case (kind)
            0: return {7'h00, 3'b000};
            1: return {7'h20, 3'b000};
            2: return {7'h00, 3'b111};
            3: return {7'h00, 3'b110};
            4: return {7'h00, 3'b100};
            5: return {7'h00, 3'b010};
            6: return {7'h00, 3'b001};
            7: return {7'h00, 3'b101};
            default: return {7'h20, 3'b101};
        endcase
    endfunction

    function automatic logic [2:0] iFunct3(input int kind);
        case (kind)
            2: return 3'b111;
            3: return 3'b110;
            4: return 3'b100;
            5: return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic legalOpcode(input logic [6:0] op);
        return op inside {rvPkg::opR, rvPkg::opImm, rvPkg::opLui,
                          rvPkg::opLoad, rvPkg::opStore, rvPkg::opJal};
    endfunction

    // x0 ignores writes
    task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            mReg[rd] = value;
        end
    endtask

    ////////////////////
    // Drivers
    ////////////////////
    task automatic issue(input logic [31:0] word, input logic expIllegal);
        @(negedge clk);
        instrValid = 1'b1;
        instr      = word;
        @(posedge clk);
        // Flag for the word just presented
        checkValue({31'b0, illegalInstr}, {31'b0, expIllegal}, "illegalInstr");
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            instrValid = 1'b0;
        end
    endtask

    // Setup, access, then bus idle
    task automatic apbTransfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(negedge clk);
        instrValid     = 1'b0;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge clk);
        // Response registered at the end of setup
        rdata          = apbRsp.prdata;
        err            = apbRsp.pslverr;
        apbReq.penable = 1'b1;
        @(negedge clk);
        // Access phase completes without wait states
        checkValue({31'b0, apbRsp.pready}, 32'd1, "pready");
        apbReq = '0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                            input logic expErr);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, addr, data, rdata, err);
        checkValue({31'b0, err}, {31'b0, expErr}, $sformatf("pslverr on write %h", addr));
    endtask

    task automatic apbRead(input logic [11:0] addr, input logic [31:0] expected,
                           input logic expErr, input string what);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b0, addr, 32'h0, rdata, err);
        checkValue(rdata, expected, what);
        checkValue({31'b0, err}, {31'b0, expErr}, {what, " pslverr"});
    endtask

    task automatic checkRegs(input string phase);
        for (int i = 0; i < numRegs; i++) begin
            apbRead(rvPkg::regBase + 12'(4 * i), mReg[i], 1'b0,
                    $sformatf("%s x%0d", phase, i));
        end
    endtask

    task automatic checkMem(input int k, input string phase);
        apbRead(rvPkg::memBase + 12'(4 * k), mMem[k], 1'b0,
                $sformatf("%s mem word %0d", phase, k));
    endtask

    ////////////////////
    // Tests
    ////////////////////
    // Random R-type, I-type and LUI with gaps
    task automatic runAluTest();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [9:0]  funct;
        logic [31:0] word;
        logic [31:0] result;
        int          kind;
        int          iKinds [5] = '{0, 2, 3, 4, 5};
        for (int n = 0; n < 200; n++) begin
            rd    = 5'($urandom);
            rs1   = 5'($urandom);
            rs2   = 5'($urandom);
            imm12 = 12'($urandom);
            imm20 = 20'($urandom);
            case ($urandom_range(0, 2))
                0: begin
                    kind   = int'($urandom_range(0, 8));
                    funct  = rFunct(kind);
                    word   = {funct[9:3], rs2, rs1, funct[2:0], rd, rvPkg::opR};
                    result = aluRef(kind, mReg[rs1], mReg[rs2]);
                end
                1: begin
                    kind   = iKinds[$urandom_range(0, 4)];
                    word   = {imm12, rs1, iFunct3(kind), rd, rvPkg::opImm};
                    result = aluRef(kind, mReg[rs1], sext12(imm12));
                end
                default: begin
                    word   = {imm20, rd, rvPkg::opLui};
                    result = {imm20, 12'h000};
                end
            endcase
            writeReg(rd, result);
            mPc = mPc + 32'd4;
            issue(word, 1'b0);
            idle(int'($urandom_range(0, 2)));
        end
        checkRegs("alu");
    endtask

    // Preload over APB, then random LW and SW
    task automatic runMemTest();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [31:0] addr;
        logic [7:0]  idx;
        logic [31:0] word;
        for (int k = 0; k < rvPkg::memWords; k++) begin
            mMem[k] = $urandom;
            apbWrite(rvPkg::memBase + 12'(4 * k), mMem[k], 1'b0);
        end
        for (int n = 0; n < 150; n++) begin
            rd    = 5'($urandom);
            rs1   = 5'($urandom);
            rs2   = 5'($urandom);
            imm12 = 12'($urandom);
            addr  = mReg[rs1] + sext12(imm12);
            idx   = addr[9:2];
            if ($urandom_range(0, 1) == 0) begin
                word      = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], rvPkg::opStore};
                mMem[idx] = mReg[rs2];
            end else begin
                word = {imm12, rs1, 3'b010, rd, rvPkg::opLoad};
                writeReg(rd, mMem[idx]);
            end
            mPc = mPc + 32'd4;
            issue(word, 1'b0);
            idle(int'($urandom_range(0, 2)));
        end
        checkRegs("mem");
        for (int k = 0; k < rvPkg::memWords; k++) begin
            checkMem(k, "mem");
        end
    endtask

    task automatic runJalTest();
        logic [4:0]  rd;
        logic [20:0] off;
        for (int n = 0; n < 20; n++) begin
            rd  = 5'($urandom);
            // Even offsets only
            off = 21'($urandom) & 21'h1F_FFFE;
            writeReg(rd, mPc + 32'd4);
            mPc = mPc + {{11{off[20]}}, off};
            issue({off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal}, 1'b0);
            apbRead(rvPkg::regBase + 12'(4 * rd), mReg[rd], 1'b0, "jal link");
            apbRead(rvPkg::pcAddr, mPc, 1'b0, "jal pc");
        end
    endtask

    // Encodings outside the supported subset
    function automatic logic [31:0] illegalWord();
        logic [31:0] w;
        logic [6:0]  f7;
        logic [2:0]  f3;
        w  = $urandom;
        f7 = w[31:25];
        f3 = w[14:12];
        case ($urandom_range(0, 3))
            0: begin
                while (legalOpcode(w[6:0])) begin
                    w[6:0] = 7'($urandom);
                end
            end
            1: begin
                // funct7 other than base and alternate
                if (f7 == 7'h00 || f7 == 7'h20) begin
                    f7 = 7'h01;
                end
                w[31:25] = f7;
                w[6:0]   = rvPkg::opR;
            end
            2: begin
                // Immediate shifts and SLTIU
                case ($urandom_range(0, 2))
                    0:       w[14:12] = 3'b001;
                    1:       w[14:12] = 3'b011;
                    default: w[14:12] = 3'b101;
                endcase
                w[6:0] = rvPkg::opImm;
            end
            default: begin
                // Byte and halfword memory access
                if (f3 == 3'b010) begin
                    f3 = 3'b000;
                end
                w[14:12] = f3;
                w[6:0]   = ($urandom_range(0, 1) == 0) ? rvPkg::opLoad : rvPkg::opStore;
            end
        endcase
        return w;
    endfunction

    task automatic runIllegalTest();
        for (int n = 0; n < 30; n++) begin
            issue(illegalWord(), 1'b1);
            idle(int'($urandom_range(0, 2)));
        end
        checkRegs("illegal");
        apbRead(rvPkg::pcAddr, mPc, 1'b0, "illegal pc");
        // Illegal stores may point anywhere
        for (int k = 0; k < rvPkg::memWords; k++) begin
            checkMem(k, "illegal");
        end
    endtask

    // Writes outside memory and unmapped reads
    task automatic runErrorTest();
        apbWrite(rvPkg::regBase + 12'd28, 32'hDEAD_BEEF, 1'b1);
        apbRead(rvPkg::regBase + 12'd28, mReg[7], 1'b0, "x7 after bad write");
        apbWrite(rvPkg::pcAddr, 32'h0000_1000, 1'b1);
        apbRead(rvPkg::pcAddr, mPc, 1'b0, "pc after bad write");
        apbRead(12'h084, 32'h0, 1'b1, "unmapped 084");
        apbRead(12'h200, 32'h0, 1'b1, "unmapped 200");
        // Memory words aliased by the low bits of the bad writes
        checkMem(7, "error");
        checkMem(32, "error");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        void'($urandom(32'h4c8a_913b));
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = 32'h0;
        apbReq     = '0;
        mPc        = 32'h0;
        for (int i = 0; i < numRegs; i++) begin
            mReg[i] = 32'h0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // Reset state of registers and PC
        checkRegs("reset");
        apbRead(rvPkg::pcAddr, 32'h0, 1'b0, "reset pc");

        runAluTest();
        runMemTest();
        runJalTest();
        runIllegalTest();
        runErrorTest();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sim/rvCore_properties.sv */
`timescale 1ns/100ps

module regFileProperties (
    input logic                       clk,
    input logic                       arstN,
    input logic                       writeEnable,
    input logic [rvPkg::regAddrW-1:0] rs1,
    input logic [rvPkg::xlen-1:0]     rdata1,
    input logic [rvPkg::regAddrW-1:0] dbgAddr,
    input logic [rvPkg::xlen-1:0]     dbgData,
    input rvPkg::apbReq_t             apbReq,
    input rvPkg::apbRsp_t             apbRsp
);

    ////////////////////
    // Register file
    ////////////////////
    // x0 reads as zero on the core and debug ports
    x0Core: assert property (@(posedge clk) disable iff (!arstN)
        rs1 == '0 |-> rdata1 == '0)
        else $error("rdata1 nonzero while rs1 is x0");

    x0Debug: assert property (@(posedge clk) disable iff (!arstN)
        dbgAddr == '0 |-> dbgData == '0)
        else $error("dbgData nonzero while dbgAddr is x0");

    // No write enable, same index, same contents one cycle later
    holdCore: assert property (@(posedge clk) disable iff (!arstN)
        !writeEnable ##1 $stable(rs1) |-> $stable(rdata1))
        else $error("register changed without writeEnable (rs1 port)");

    holdDebug: assert property (@(posedge clk) disable iff (!arstN)
        !writeEnable ##1 $stable(dbgAddr) |-> $stable(dbgData))
        else $error("register changed without writeEnable (debug port)");

    ////////////////////
    // APB port
    ////////////////////
    slverrPhase: assert property (@(posedge clk) disable iff (!arstN)
        apbRsp.pslverr |-> apbReq.psel && apbReq.penable)
        else $error("pslverr high outside the access phase");

endmodule

// Top level sees both the register file nets and the APB bundles
bind rvCore regFileProperties regFileProperties_inst (
    .clk         (clk),
    .arstN       (arstN),
    .writeEnable (regWe),
    .rs1         (dec.rs1),
    .rdata1      (rdata1),
    .dbgAddr     (dbgRegIdx),
    .dbgData     (dbgRegData),
    .apbReq      (apbReq),
    .apbRsp      (apbRsp)
);

/* hw/rvCore.sv */
`timescale 1ns/100ps

module rvCore (
    input  logic           clk,
    input  logic           arstN,
    input  logic           instrValid,
    input  logic [31:0]    instr,
    input  rvPkg::apbReq_t apbReq,
    output rvPkg::apbRsp_t apbRsp,
    output logic           illegalInstr
);

    rvPkg::decodedInstr_t dec;

    logic [rvPkg::xlen-1:0]     pc;
    logic [rvPkg::xlen-1:0]     pcNext;
    logic [rvPkg::xlen-1:0]     rdata1;
    logic [rvPkg::xlen-1:0]     rdata2;
    logic [rvPkg::xlen-1:0]     operandB;
    logic [rvPkg::xlen-1:0]     aluResult;
    logic [rvPkg::xlen-1:0]     memRdata;
    logic                       regWe;
    logic                       coreWe;
    // Debug side
    logic [rvPkg::regAddrW-1:0] dbgRegIdx;
    logic [rvPkg::xlen-1:0]     dbgRegData;
    logic [rvPkg::memAddrW-1:0] dbgMemIdx;
    logic [rvPkg::xlen-1:0]     dbgMemData;
    logic [rvPkg::xlen-1:0]     dbgMemWdata;
    logic                       dbgMemWe;
    logic                       dbgMemDropped;

    instrDecode instrDecode_inst (
        .instr (instr),
        .dec   (dec)
    );

    ////////////////////
    // Commit control
    ////////////////////
    // Decoder already clears the enables of illegal encodings
    assign regWe        = instrValid && dec.regWrite;
    assign coreWe       = instrValid && dec.memWrite;
    assign illegalInstr = instrValid && dec.illegal;

    // JAL jumps relative, everything else falls through
    assign pcNext = dec.isJal ? pc + dec.imm : pc + 32'd4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (instrValid && !dec.illegal) begin
            pc <= pcNext;
        end
    end

    regFile regFile_inst (
        .clk         (clk),
        .arstN       (arstN),
        .writeEnable (regWe),
        .rd          (dec.rd),
        .rs1         (dec.rs1),
        .rs2         (dec.rs2),
        .dbgAddr     (dbgRegIdx),
        .wbSel       (dec.wbSel),
        .pcValue     (pc),
        .aluResult   (aluResult),
        .memData     (memRdata),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .dbgData     (dbgRegData)
    );

    // Operand B from register or immediate
    assign operandB = dec.useImm ? dec.imm : rdata2;

    alu alu_inst (
        .a      (rdata1),
        .b      (operandB),
        .op     (dec.aluOp),
        .result (aluResult)
    );

    // Word index from bits 9:2 of the address sum
    dataMem dataMem_inst (
        .clk        (clk),
        .coreWe     (coreWe),
        .coreIdx    (aluResult[9:2]),
        .coreWdata  (rdata2),
        .apbWe      (dbgMemWe),
        .apbIdx     (dbgMemIdx),
        .apbWdata   (dbgMemWdata),
        .coreRdata  (memRdata),
        .apbRdata   (dbgMemData),
        .apbDropped (dbgMemDropped)
    );

    apbDebugPort apbDebugPort_inst (
        .clk        (clk),
        .arstN      (arstN),
        .req        (apbReq),
        .pcValue    (pc),
        .regData    (dbgRegData),
        .memData    (dbgMemData),
        .memDropped (dbgMemDropped),
        .rsp        (apbRsp),
        .regIdx     (dbgRegIdx),
        .memIdx     (dbgMemIdx),
        .memWe      (dbgMemWe),
        .memWdata   (dbgMemWdata)
    );

endmodule

/* hw/apbDebugPort.sv */
`timescale 1ns/100ps

module apbDebugPort (
    input  logic                       clk,
    input  logic                       arstN,
    input  rvPkg::apbReq_t             req,
    input  logic [rvPkg::xlen-1:0]     pcValue,
    input  logic [rvPkg::xlen-1:0]     regData,
    input  logic [rvPkg::xlen-1:0]     memData,
    input  logic                       memDropped,
    output rvPkg::apbRsp_t             rsp,
    output logic [rvPkg::regAddrW-1:0] regIdx,
    output logic [rvPkg::memAddrW-1:0] memIdx,
    output logic                       memWe,
    output logic [rvPkg::xlen-1:0]     memWdata
);

    logic                   setupPhase;
    logic                   accessPhase;
    logic                   aligned;
    logic                   inReg;
    logic                   isPc;
    logic                   inMem;
    logic                   badAccess;
    logic [rvPkg::xlen-1:0] readWord;
    logic [rvPkg::xlen-1:0] prdataQ;
    logic                   pslverrQ;

    assign setupPhase  = req.psel && !req.penable;
    assign accessPhase = req.psel && req.penable;

    ////////////////////
    // Address decode
    ////////////////////
    assign aligned = (req.paddr[1:0] == 2'b00);
    // Registers 0x000 to 0x07C
    assign inReg   = aligned && (req.paddr[11:7] == rvPkg::regBase[11:7]);
    assign isPc    = (req.paddr == rvPkg::pcAddr);
    // Memory 0x400 to 0x7FC
    assign inMem   = aligned && (req.paddr[11:10] == rvPkg::memBase[11:10]);

    assign regIdx  = req.paddr[6:2];
    assign memIdx  = req.paddr[9:2];

    // Only the memory range is writable
    assign badAccess = req.pwrite ? !inMem : !(inReg || isPc || inMem);

    always_comb begin
        if (inReg) begin
            readWord = regData;
        end else if (isPc) begin
            readWord = pcValue;
        end else if (inMem) begin
            readWord = memData;
        end else begin
            // Unmapped reads return zero
            readWord = '0;
        end
    end

    // Capture at the end of setup, held for the access phase
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prdataQ  <= '0;
            pslverrQ <= 1'b0;
        end else if (setupPhase) begin
            prdataQ  <= req.pwrite ? '0 : readWord;
            pslverrQ <= badAccess;
        end else begin
            pslverrQ <= 1'b0;
        end
    end

    ////////////////////
    // Memory write and response
    ////////////////////
    assign memWe    = accessPhase && req.pwrite && inMem;
    assign memWdata = req.pwdata;

    assign rsp.prdata  = prdataQ;
    // Never waits
    assign rsp.pready  = 1'b1;
    // A dropped write reports an error in its own access phase
    assign rsp.pslverr = pslverrQ || memDropped;

endmodule

/* hw/dataMem.sv */
`timescale 1ns/100ps

module dataMem (
    input  logic                       clk,
    input  logic                       coreWe,
    input  logic [rvPkg::memAddrW-1:0] coreIdx,
    input  logic [rvPkg::xlen-1:0]     coreWdata,
    input  logic                       apbWe,
    input  logic [rvPkg::memAddrW-1:0] apbIdx,
    input  logic [rvPkg::xlen-1:0]     apbWdata,
    output logic [rvPkg::xlen-1:0]     coreRdata,
    output logic [rvPkg::xlen-1:0]     apbRdata,
    output logic                       apbDropped
);

    logic [rvPkg::xlen-1:0] mem [rvPkg::memWords];

    ////////////////////
    // Write ports
    ////////////////////
    // Core store takes priority over the debug write
    always_ff @(posedge clk) begin
        if (coreWe) begin
            mem[coreIdx] <= coreWdata;
        end else if (apbWe) begin
            mem[apbIdx] <= apbWdata;
        end
    end

    // Debug write lost to a store in the same cycle
    assign apbDropped = coreWe && apbWe;

    ////////////////////
    // Read ports
    ////////////////////
    assign coreRdata = mem[coreIdx];
    assign apbRdata  = mem[apbIdx];

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  rvPkg::aluOp_t          op,
    output logic [rvPkg::xlen-1:0] result
);

    // Shift amount from low five bits of b
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rvPkg::aluAdd:   result = a + b;
            rvPkg::aluSub:   result = a - b;
            rvPkg::aluAnd:   result = a & b;
            rvPkg::aluOr:    result = a | b;
            rvPkg::aluXor:   result = a ^ b;
            // Signed compare, result 0 or 1
            rvPkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
            rvPkg::aluSll:   result = a << shamt;
            rvPkg::aluSrl:   result = a >> shamt;
            // Arithmetic shift keeps the sign
            rvPkg::aluSra:   result = $unsigned($signed(a) >>> shamt);
            // LUI, upper immediate straight through
            rvPkg::aluPassB: result = b;
            default:         result = '0;
        endcase
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      writeEnable,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] dbgAddr,
    input  rvPkg::wbSel_t             wbSel,
    input  logic [rvPkg::xlen-1:0]    pcValue,
    input  logic [rvPkg::xlen-1:0]    aluResult,
    input  logic [rvPkg::xlen-1:0]    memData,
    output logic [rvPkg::xlen-1:0]    rdata1,
    output logic [rvPkg::xlen-1:0]    rdata2,
    output logic [rvPkg::xlen-1:0]    dbgData
);

    localparam int numRegs = 2 ** rvPkg::regAddrW;

    logic [rvPkg::xlen-1:0] regs [numRegs];
    logic [rvPkg::xlen-1:0] wdata;

    ////////////////////
    // Write-back select
    ////////////////////
    always_comb begin
        case (wbSel)
            rvPkg::wbMem:     wdata = memData;
            rvPkg::wbAlu:     wdata = aluResult;
            // Link value, PC of the current instruction plus 4
            rvPkg::wbPcPlus4: wdata = pcValue + 32'd4;
            default:          wdata = aluResult;
        endcase
    end

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////
    // Core operands
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];
    // Debug read for APB
    assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

/* hw/instrDecode.sv */
`timescale 1ns/100ps

module instrDecode (
    input  logic [31:0]          instr,
    output rvPkg::decodedInstr_t dec
);

    // Raw instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Immediates per format
    logic [rvPkg::xlen-1:0] immI;
    logic [rvPkg::xlen-1:0] immS;
    logic [rvPkg::xlen-1:0] immU;
    logic [rvPkg::xlen-1:0] immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immU = {instr[31:12], 12'b0};
    // J format, offset bit 0 always zero
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec       = '0;
        dec.rs1   = instr[19:15];
        dec.rs2   = instr[24:20];
        dec.rd    = instr[11:7];
        dec.aluOp = rvPkg::aluAdd;
        dec.wbSel = rvPkg::wbAlu;

        case (opcode)
            rvPkg::opR: begin
                dec.regWrite = 1'b1;
                // funct7 selects SUB and SRA, everything else needs zero
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.aluOp = rvPkg::aluAdd;
                    {7'h20, 3'b000}: dec.aluOp = rvPkg::aluSub;
                    {7'h00, 3'b001}: dec.aluOp = rvPkg::aluSll;
                    {7'h00, 3'b010}: dec.aluOp = rvPkg::aluSlt;
                    {7'h00, 3'b100}: dec.aluOp = rvPkg::aluXor;
                    {7'h00, 3'b101}: dec.aluOp = rvPkg::aluSrl;
                    {7'h20, 3'b101}: dec.aluOp = rvPkg::aluSra;
                    {7'h00, 3'b110}: dec.aluOp = rvPkg::aluOr;
                    {7'h00, 3'b111}: dec.aluOp = rvPkg::aluAnd;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            rvPkg::opImm: begin
                dec.regWrite = 1'b1;
                dec.useImm   = 1'b1;
                dec.imm      = immI;
                // No immediate shifts or SLTIU here
                case (funct3)
                    3'b000:  dec.aluOp = rvPkg::aluAdd;
                    3'b010:  dec.aluOp = rvPkg::aluSlt;
                    3'b100:  dec.aluOp = rvPkg::aluXor;
                    3'b110:  dec.aluOp = rvPkg::aluOr;
                    3'b111:  dec.aluOp = rvPkg::aluAnd;
                    default: dec.illegal = 1'b1;
                endcase
            end
            rvPkg::opLui: begin
                dec.regWrite = 1'b1;
                dec.useImm   = 1'b1;
                dec.imm      = immU;
                dec.aluOp    = rvPkg::aluPassB;
            end
            rvPkg::opLoad: begin
                // Word loads only
                dec.regWrite = 1'b1;
                dec.useImm   = 1'b1;
                dec.imm      = immI;
                dec.wbSel    = rvPkg::wbMem;
                dec.illegal  = (funct3 != 3'b010);
            end
            rvPkg::opStore: begin
                dec.memWrite = 1'b1;
                dec.useImm   = 1'b1;
                dec.imm      = immS;
                dec.illegal  = (funct3 != 3'b010);
            end
            rvPkg::opJal: begin
                dec.regWrite = 1'b1;
                dec.imm      = immJ;
                dec.wbSel    = rvPkg::wbPcPlus4;
                dec.isJal    = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase

        // Illegal encodings leave all state alone
        if (dec.illegal) begin
            dec.regWrite = 1'b0;
            dec.memWrite = 1'b0;
            dec.isJal    = 1'b0;
        end
    end

endmodule

/* hw/rvPkg.sv */
package rvPkg;

    ////////////////////
    // Widths and depths
    ////////////////////
    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int memWords = 256;
    localparam int memAddrW = 8;
    localparam int apbAddrW = 12;

    // Debug address map in byte addresses
    localparam logic [apbAddrW-1:0] regBase = 12'h000;
    localparam logic [apbAddrW-1:0] pcAddr  = 12'h080;
    localparam logic [apbAddrW-1:0] memBase = 12'h400;

    ////////////////////
    // Opcodes
    ////////////////////
    localparam logic [6:0] opR     = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opJal   = 7'b1101111;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluSra, aluPassB
    } aluOp_t;

    // Write-back source for the register file
    typedef enum logic [1:0] {
        wbMem     = 2'd0,
        wbAlu     = 2'd1,
        wbPcPlus4 = 2'd2
    } wbSel_t;

    typedef struct packed {
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rd;
        aluOp_t              aluOp;
        logic [xlen-1:0]     imm;
        logic                useImm;
        wbSel_t              wbSel;
        logic                regWrite;
        logic                memWrite;
        logic                isJal;
        logic                illegal;
    } decodedInstr_t;

    ////////////////////
    // APB bundles
    ////////////////////
    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [apbAddrW-1:0] paddr;
        logic [xlen-1:0]     pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [xlen-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apbRsp_t;

endpackage
